/* cpuPkg.sv */
`include "cpu_macros.svh"

package cpuPkg;

	// Data path and instruction word
	typedef logic [31:0] word_t;

	// Register number in the 32-entry file
	typedef logic [4:0] regAddr_t;

	typedef logic [2:0] aluOp_t;

	// Word addresses into the two memories
	typedef logic [`IMEM_AW-1:0] imemAddr_t;
	typedef logic [`DMEM_AW-1:0] dmemAddr_t;

	// One byte on the serial output
	typedef logic [7:0] serialByte_t;

endpackage

/* cpuTop.sv */
module cpuTop (
	input  logic                clock,
	input  logic                i_rst,
	input  logic                i_progWe,
	input  cpuPkg::imemAddr_t   i_progAddr,
	input  cpuPkg::word_t       i_progData,
	output cpuPkg::serialByte_t o_serialOut,
	output logic                o_serialWren
);

	cpuPkg::word_t    instrIfId;
	cpuPkg::word_t    pcPlus4IfId;
	logic             validIfId;
	logic             stall;
	logic             redirect;
	cpuPkg::word_t    target;
	logic             wbWrite;
	cpuPkg::regAddr_t wbDest;
	cpuPkg::word_t    wbData;

	idExIf  idEx ();
	exMemIf exMem ();

	fetchStage fetch (
		.clock(clock),
		.i_rst(i_rst),
		.i_stall(stall),
		.i_redirect(redirect),
		.i_target(target),
		.i_progWe(i_progWe),
		.i_progAddr(i_progAddr),
		.i_progData(i_progData),
		.o_instr(instrIfId),
		.o_pcPlus4(pcPlus4IfId),
		.o_valid(validIfId)
	);

	decodeStage decode (
		.clock(clock),
		.i_rst(i_rst),
		.i_instr(instrIfId),
		.i_pcPlus4(pcPlus4IfId),
		.i_valid(validIfId),
		.i_redirect(redirect),
		.i_wbWrite(wbWrite),
		.i_wbDest(wbDest),
		.i_wbData(wbData),
		.o_stall(stall),
		.idEx(idEx.producer)
	);

	executeStage execute (
		.clock(clock),
		.i_rst(i_rst),
		.i_wbWrite(wbWrite),
		.i_wbDest(wbDest),
		.i_wbData(wbData),
		.o_redirect(redirect),
		.o_target(target),
		.idEx(idEx.consumer),
		.exMem(exMem.producer),
		.exMemFwd(exMem.fwd)
	);

	memoryStage memory (
		.clock(clock),
		.i_rst(i_rst),
		.exMem(exMem.consumer),
		.o_wbWrite(wbWrite),
		.o_wbDest(wbDest),
		.o_wbData(wbData),
		.o_serialOut(o_serialOut),
		.o_serialWren(o_serialWren)
	);

endmodule

/* cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Memory word-address widths
`define IMEM_AW 8
`define DMEM_AW 8

// -------------------------------------------------------------------------
// Opcodes and R-type function codes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDIU 6'h09
`define OP_LW    6'h23
`define OP_SW    6'h2B

`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_SLT  6'h2A

// -------------------------------------------------------------------------
// ALU operations
`define ALU_ADD 3'd0
`define ALU_SUB 3'd1
`define ALU_AND 3'd2
`define ALU_OR  3'd3
`define ALU_SLT 3'd4

// Serial port, compared against the low half of the byte address
`define SERIAL_ADDR 16'hFFFC

`endif

/* decodeStage.sv */
`include "cpu_macros.svh"

module decodeStage (
	input  logic             clock,
	input  logic             i_rst,
	input  cpuPkg::word_t    i_instr,
	input  cpuPkg::word_t    i_pcPlus4,
	input  logic             i_valid,
	input  logic             i_redirect,
	input  logic             i_wbWrite,
	input  cpuPkg::regAddr_t i_wbDest,
	input  cpuPkg::word_t    i_wbData,
	output logic             o_stall,
	idExIf.producer          idEx
);

	cpuPkg::word_t    regFile [32];
	cpuPkg::regAddr_t rs;
	cpuPkg::regAddr_t rt;
	cpuPkg::regAddr_t dest;
	cpuPkg::aluOp_t   aluOp;
	cpuPkg::word_t    rsData;
	cpuPkg::word_t    rtData;
	logic [5:0]       opcode;
	logic [5:0]       funct;
	logic             useRs;
	logic             useRt;
	logic             useImm;
	logic             memRead;
	logic             memWrite;
	logic             regWrite;
	logic             isBranch;
	logic             branchOnEqual;
	logic             isJump;

	assign opcode = i_instr[31:26];
	assign funct  = i_instr[5:0];
	assign rs     = i_instr[25:21];
	assign rt     = i_instr[20:16];

	always_comb begin
		aluOp         = `ALU_ADD;
		useRs         = 1'b1;
		useRt         = 1'b0;
		useImm        = 1'b1;
		memRead       = 1'b0;
		memWrite      = 1'b0;
		regWrite      = 1'b0;
		isBranch      = 1'b0;
		branchOnEqual = 1'b0;
		isJump        = 1'b0;
		dest          = rt;
		case (opcode)
			`OP_RTYPE: begin
				useRt    = 1'b1;
				useImm   = 1'b0;
				dest     = i_instr[15:11];
				regWrite = 1'b1;
				case (funct)
					`FN_ADDU: aluOp = `ALU_ADD;
					`FN_SUBU: aluOp = `ALU_SUB;
					`FN_AND:  aluOp = `ALU_AND;
					`FN_OR:   aluOp = `ALU_OR;
					`FN_SLT:  aluOp = `ALU_SLT;
					default:  regWrite = 1'b0;
				endcase
			end
			`OP_ADDIU: regWrite = 1'b1;
			`OP_LW: begin
				memRead  = 1'b1;
				regWrite = 1'b1;
			end
			`OP_SW: begin
				useRt    = 1'b1;
				memWrite = 1'b1;
			end
			`OP_BEQ, `OP_BNE: begin
				useRt         = 1'b1;
				isBranch      = 1'b1;
				branchOnEqual = (opcode == `OP_BEQ);
			end
			`OP_J: begin
				useRs  = 1'b0;
				isJump = 1'b1;
			end
			default: useRs = 1'b0;
		endcase
	end

	// -------------------------------------------------------------------------
	// Register file with writeback passing straight through
	always_ff @(posedge clock) begin
		if (i_rst) begin
			for (int i = 0; i < 32; i++)
				regFile[i] <= '0;
		end else if (i_wbWrite && i_wbDest != '0) begin
			regFile[i_wbDest] <= i_wbData;
		end
	end

	assign rsData = (rs == '0) ? '0 : (i_wbWrite && i_wbDest == rs) ? i_wbData : regFile[rs];
	assign rtData = (rt == '0) ? '0 : (i_wbWrite && i_wbDest == rt) ? i_wbData : regFile[rt];

	// Load in EX feeding this instruction
	assign o_stall = i_valid && idEx.valid && idEx.memRead && idEx.dest != '0
		&& ((useRs && idEx.dest == rs) || (useRt && idEx.dest == rt));

	// -------------------------------------------------------------------------
	// ID/EX register
	always_ff @(posedge clock) begin
		if (i_rst || i_redirect || o_stall || !i_valid) begin
			idEx.valid    <= 1'b0;
			idEx.memRead  <= 1'b0;
			idEx.memWrite <= 1'b0;
			idEx.regWrite <= 1'b0;
			idEx.isBranch <= 1'b0;
			idEx.isJump   <= 1'b0;
		end else begin
			idEx.valid    <= 1'b1;
			idEx.memRead  <= memRead;
			idEx.memWrite <= memWrite;
			idEx.regWrite <= regWrite;
			idEx.isBranch <= isBranch;
			idEx.isJump   <= isJump;
		end
	end

	always_ff @(posedge clock) begin
		idEx.aluOp         <= aluOp;
		idEx.useImm        <= useImm;
		idEx.branchOnEqual <= branchOnEqual;
		idEx.rsData        <= rsData;
		idEx.rtData        <= rtData;
		idEx.rs            <= rs;
		idEx.rt            <= rt;
		idEx.dest          <= dest;
		idEx.imm           <= {{16{i_instr[15]}}, i_instr[15:0]};
		idEx.pcPlus4       <= i_pcPlus4;
		idEx.jumpTarget    <= {i_pcPlus4[31:28], i_instr[25:0], 2'b00};
	end

	// A load in EX is never also a branch or jump
	assert property (@(posedge clock) disable iff (i_rst) !(o_stall && i_redirect));
	// Fetch drops its slot on a redirect
	assert property (@(posedge clock) disable iff (i_rst) i_redirect |=> !i_valid);

endmodule

/* executeStage.sv */
`include "cpu_macros.svh"

module executeStage (
	input  logic             clock,
	input  logic             i_rst,
	input  logic             i_wbWrite,
	input  cpuPkg::regAddr_t i_wbDest,
	input  cpuPkg::word_t    i_wbData,
	output logic             o_redirect,
	output cpuPkg::word_t    o_target,
	idExIf.consumer          idEx,
	exMemIf.producer         exMem,
	exMemIf.fwd              exMemFwd
);

	cpuPkg::word_t opA;
	cpuPkg::word_t opB;
	cpuPkg::word_t aluB;
	cpuPkg::word_t aluResult;

	// MEM result first, then WB data, else the value read in decode
	function automatic cpuPkg::word_t pickOperand(
		input cpuPkg::regAddr_t src,
		input cpuPkg::word_t    regVal
	);
		if (src == '0)
			return regVal;
		if (exMemFwd.valid && exMemFwd.regWrite && !exMemFwd.memRead && exMemFwd.dest == src)
			return exMemFwd.aluResult;
		if (i_wbWrite && i_wbDest == src)
			return i_wbData;
		return regVal;
	endfunction

	always_comb begin
		opA = pickOperand(idEx.rs, idEx.rsData);
		opB = pickOperand(idEx.rt, idEx.rtData);
	end

	// -------------------------------------------------------------------------
	// ALU
	assign aluB = idEx.useImm ? idEx.imm : opB;

	always_comb begin
		case (idEx.aluOp)
			`ALU_ADD: aluResult = opA + aluB;
			`ALU_SUB: aluResult = opA - aluB;
			`ALU_AND: aluResult = opA & aluB;
			`ALU_OR:  aluResult = opA | aluB;
			`ALU_SLT: aluResult = {31'b0, $signed(opA) < $signed(aluB)};
			default:  aluResult = '0;
		endcase
	end

	// Branch taken when the compare matches the BEQ/BNE sense
	assign o_redirect = idEx.valid && (idEx.isJump
		|| (idEx.isBranch && ((opA == opB) == idEx.branchOnEqual)));
	assign o_target = idEx.isJump ? idEx.jumpTarget : idEx.pcPlus4 + {idEx.imm[29:0], 2'b00};

	// -------------------------------------------------------------------------
	// EX/MEM register
	always_ff @(posedge clock) begin
		if (i_rst || !idEx.valid) begin
			exMem.valid    <= 1'b0;
			exMem.memRead  <= 1'b0;
			exMem.memWrite <= 1'b0;
			exMem.regWrite <= 1'b0;
		end else begin
			exMem.valid    <= 1'b1;
			exMem.memRead  <= idEx.memRead;
			exMem.memWrite <= idEx.memWrite;
			exMem.regWrite <= idEx.regWrite;
		end
	end

	always_ff @(posedge clock) begin
		exMem.dest      <= idEx.dest;
		exMem.aluResult <= aluResult;
		exMem.storeData <= opB;
	end

endmodule

/* fetchStage.sv */
`include "cpu_macros.svh"

module fetchStage (
	input  logic              clock,
	input  logic              i_rst,
	input  logic              i_stall,
	input  logic              i_redirect,
	input  cpuPkg::word_t     i_target,
	input  logic              i_progWe,
	input  cpuPkg::imemAddr_t i_progAddr,
	input  cpuPkg::word_t     i_progData,
	output cpuPkg::word_t     o_instr,
	output cpuPkg::word_t     o_pcPlus4,
	output logic              o_valid
);

	cpuPkg::word_t     instrMem [2**`IMEM_AW];
	cpuPkg::word_t     pc;
	cpuPkg::word_t     pcPlus4;
	cpuPkg::imemAddr_t pcIndex;

	assign pcPlus4 = pc + 32'd4;
	assign pcIndex = pc[`IMEM_AW+1:2];

	// Program image is written only while the core sits in reset
	always_ff @(posedge clock) begin
		if (i_rst && i_progWe)
			instrMem[i_progAddr] <= i_progData;
	end

	always_ff @(posedge clock) begin
		if (i_rst)
			pc <= '0;
		else if (i_redirect)
			pc <= i_target;
		else if (!i_stall)
			pc <= pcPlus4;
	end

	// -------------------------------------------------------------------------
	// IF/ID register
	always_ff @(posedge clock) begin
		if (i_rst || i_redirect)
			o_valid <= 1'b0;
		else if (!i_stall)
			o_valid <= 1'b1;
	end

	always_ff @(posedge clock) begin
		if (!i_stall) begin
			o_instr   <= instrMem[pcIndex];
			o_pcPlus4 <= pcPlus4;
		end
	end

	assert property (@(posedge clock) i_progWe |-> i_rst);

endmodule

/* memoryStage.sv */
`include "cpu_macros.svh"

module memoryStage (
	input  logic                clock,
	input  logic                i_rst,
	exMemIf.consumer            exMem,
	output logic                o_wbWrite,
	output cpuPkg::regAddr_t    o_wbDest,
	output cpuPkg::word_t       o_wbData,
	output cpuPkg::serialByte_t o_serialOut,
	output logic                o_serialWren
);

	cpuPkg::word_t     dataMem [2**`DMEM_AW];
	cpuPkg::dmemAddr_t wordAddr;
	cpuPkg::word_t     loadData;
	logic              isSerial;
	logic              serialStore;
	logic              wbIsLoad;
	cpuPkg::word_t     wbResult;
	cpuPkg::word_t     wbLoadData;

	assign wordAddr    = exMem.aluResult[`DMEM_AW+1:2];
	assign isSerial    = (exMem.aluResult[15:0] == `SERIAL_ADDR);
	assign serialStore = exMem.valid && exMem.memWrite && isSerial;
	assign loadData    = dataMem[wordAddr];

	always_ff @(posedge clock) begin
		if (exMem.valid && exMem.memWrite && !isSerial)
			dataMem[wordAddr] <= exMem.storeData;
	end

	// -------------------------------------------------------------------------
	// Serial output, one-cycle write pulse
	always_ff @(posedge clock) begin
		if (i_rst)
			o_serialWren <= 1'b0;
		else
			o_serialWren <= serialStore;
	end

	always_ff @(posedge clock) begin
		if (serialStore)
			o_serialOut <= exMem.storeData[7:0];
	end

	// -------------------------------------------------------------------------
	// MEM/WB register
	always_ff @(posedge clock) begin
		if (i_rst) begin
			o_wbWrite <= 1'b0;
			wbIsLoad  <= 1'b0;
		end else begin
			o_wbWrite <= exMem.valid && exMem.regWrite;
			wbIsLoad  <= exMem.memRead;
		end
	end

	always_ff @(posedge clock) begin
		o_wbDest   <= exMem.dest;
		wbResult   <= exMem.aluResult;
		wbLoadData <= loadData;
	end

	assign o_wbData = wbIsLoad ? wbLoadData : wbResult;

	// Decode never emits a load that is also a store
	assert property (@(posedge clock) disable iff (i_rst)
		exMem.valid |-> !(exMem.memRead && exMem.memWrite));

endmodule

/* pipeIf.sv */
// ID/EX pipeline register contents
interface idExIf;
	logic              valid;
	cpuPkg::aluOp_t    aluOp;
	logic              useImm;
	logic              memRead;
	logic              memWrite;
	logic              regWrite;
	logic              isBranch;
	logic              branchOnEqual;
	logic              isJump;
	cpuPkg::word_t     rsData;
	cpuPkg::word_t     rtData;
	cpuPkg::regAddr_t  rs;
	cpuPkg::regAddr_t  rt;
	cpuPkg::regAddr_t  dest;
	cpuPkg::word_t     imm;
	cpuPkg::word_t     pcPlus4;
	cpuPkg::word_t     jumpTarget;

	modport producer (
		output valid, aluOp, useImm, memRead, memWrite, regWrite, isBranch,
			branchOnEqual, isJump, rsData, rtData, rs, rt, dest, imm, pcPlus4, jumpTarget
	);
	modport consumer (
		input valid, aluOp, useImm, memRead, memWrite, regWrite, isBranch,
			branchOnEqual, isJump, rsData, rtData, rs, rt, dest, imm, pcPlus4, jumpTarget
	);
endinterface

// EX/MEM pipeline register contents
interface exMemIf;
	logic              valid;
	logic              memRead;
	logic              memWrite;
	logic              regWrite;
	cpuPkg::regAddr_t  dest;
	cpuPkg::word_t     aluResult;
	cpuPkg::word_t     storeData;

	modport producer (output valid, memRead, memWrite, regWrite, dest, aluResult, storeData);
	modport consumer (input valid, memRead, memWrite, regWrite, dest, aluResult, storeData);
	// Read back by execute for MEM forwarding
	modport fwd (input valid, memRead, regWrite, dest, aluResult);
endinterface

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tbTop -f sim.f -o tbSim \
	&& ./obj_dir/tbSim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
	|| { echo "simulation failed"; exit 1; }

/* sim.f */
+incdir+.
cpuPkg.sv
pipeIf.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
cpuTop.sv
tbChecker.sv
tbTop.sv

/* tbChecker.sv */
module tbChecker (
	input  logic                clock,
	input  logic                i_rst,
	input  logic                i_start,
	input  logic [8*16-1:0]     i_name,
	input  int                  i_expCount,
	input  cpuPkg::serialByte_t i_expBytes [16],
	input  cpuPkg::serialByte_t i_serialOut,
	input  logic                i_serialWren,
	output logic                o_done,
	output logic                o_pass
);
	timeunit 1ns;
	timeprecision 1ns;

	// Set when a write pulse shows up during the reset window
	logic resetPulse;

	// ------------------------------------------------------------------------
	// Serial bytes in order, then a quiet window
	task automatic compareBytes();
		int   got;
		int   waited;
		logic failed;
		got    = 0;
		failed = 1'b0;
		o_done = 1'b0;
		while (!failed && got < i_expCount) begin
			waited = 0;
			do begin
				@(negedge clock);
				waited++;
			end while (!i_serialWren && waited < 2000);
			if (!i_serialWren) begin
				$display("FAIL %0s: too few serial bytes arrived, %0d of %0d",
					i_name, got, i_expCount);
				failed = 1'b1;
			end else if (i_serialOut !== i_expBytes[got]) begin
				$display("mismatch %0s: byte %0d expected %02h actual %02h",
					i_name, got, i_expBytes[got], i_serialOut);
				failed = 1'b1;
			end else begin
				got++;
			end
		end
		// Skipped stores must never reach the port
		waited = 0;
		while (!failed && waited < 50) begin
			@(negedge clock);
			waited++;
			if (i_serialWren) begin
				$display("FAIL %0s: extra serial byte %02h after the expected ones",
					i_name, i_serialOut);
				failed = 1'b1;
			end
		end
		if (!failed && resetPulse) begin
			$display("FAIL %0s: serial write pulse seen while reset was held", i_name);
			failed = 1'b1;
		end
		if (!failed)
			$display("pass %0s: %0d serial bytes matched", i_name, got);
		resetPulse = 1'b0;
		o_pass     = !failed;
		o_done     = 1'b1;
	endtask

	// Controls sampled on the rising edge, DUT outputs on the falling edge
	initial begin
		logic rstSeen;
		logic startSeen;
		o_done     = 1'b0;
		o_pass     = 1'b0;
		resetPulse = 1'b0;
		forever begin
			@(posedge clock);
			rstSeen   = i_rst;
			startSeen = i_start;
			@(negedge clock);
			if (rstSeen && i_serialWren)
				resetPulse = 1'b1;
			if (startSeen)
				compareBytes();
		end
	end

endmodule

/* tbTop.sv */
`include "cpu_macros.svh"

module tbTop;
	timeunit 1ns;
	timeprecision 1ns;

	logic                clock;
	logic                rst;
	logic                progWe;
	cpuPkg::imemAddr_t   progAddr;
	cpuPkg::word_t       progData;
	cpuPkg::serialByte_t serialOut;
	logic                serialWren;
	logic                start;
	logic                done;
	logic                testPass;
	logic [8*16-1:0]     testName;
	int                  expCount;
	cpuPkg::serialByte_t expBytes [16];
	cpuPkg::word_t       progWords [$];
	int                  passCount;
	int                  failCount;
	logic                aborted;

	initial clock = 1'b0;
	always #50 clock = ~clock;

	cpuTop dut (
		.clock(clock),
		.i_rst(rst),
		.i_progWe(progWe),
		.i_progAddr(progAddr),
		.i_progData(progData),
		.o_serialOut(serialOut),
		.o_serialWren(serialWren)
	);

	tbChecker scoreboard (
		.clock(clock),
		.i_rst(rst),
		.i_start(start),
		.i_name(testName),
		.i_expCount(expCount),
		.i_expBytes(expBytes),
		.i_serialOut(serialOut),
		.i_serialWren(serialWren),
		.o_done(done),
		.o_pass(testPass)
	);

	// ------------------------------------------------------------------------
	// Reset for two cycles, load the program, release and wait for a verdict
	task automatic loadAndRun();
		int waited;
		@(negedge clock);
		rst = 1'b1;
		repeat (2) @(negedge clock);
		for (int i = 0; i < progWords.size(); i++) begin
			progWe   = 1'b1;
			progAddr = i[`IMEM_AW-1:0];
			progData = progWords[i];
			@(negedge clock);
		end
		progWe = 1'b0;
		rst    = 1'b0;
		start  = 1'b1;
		@(negedge clock);
		start  = 1'b0;
		waited = 0;
		do begin
			@(posedge clock);
			waited++;
		end while (!done && waited < 40000);
		if (!done) begin
			$display("test %0s: checker gave no verdict within 40000 cycles", testName);
			aborted = 1'b1;
		end else if (testPass)
			passCount++;
		else
			failCount++;
	endtask

	// ------------------------------------------------------------------------
	initial begin
		int                fd;
		int                code;
		int                wordCount;
		int                byteCount;
		logic [8*100-1:0]  line;
		cpuPkg::word_t     value;
		logic              moreTests;
		rst       = 1'b1;
		progWe    = 1'b0;
		progAddr  = '0;
		progData  = '0;
		start     = 1'b0;
		testName  = '0;
		expCount  = 0;
		passCount = 0;
		failCount = 0;
		aborted   = 1'b0;
		moreTests = 1'b1;
		foreach (expBytes[i])
			expBytes[i] = '0;
		fd = $fopen("tests_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open tests_input.txt");
			aborted = 1'b1;
		end else begin
			// Two lines describe the columns
			code = $fgets(line, fd);
			code = $fgets(line, fd);
		end
		while (!aborted && moreTests) begin
			code = $fscanf(fd, "%s %d %d", testName, wordCount, byteCount);
			if (code != 3) begin
				moreTests = 1'b0;
			end else if (byteCount > 16 || wordCount > 2**`IMEM_AW) begin
				$display("test %0s is larger than the testbench can hold", testName);
				aborted = 1'b1;
			end else begin
				progWords.delete();
				for (int i = 0; i < wordCount; i++) begin
					if ($fscanf(fd, "%h", value) != 1)
						aborted = 1'b1;
					progWords.push_back(value);
				end
				for (int i = 0; i < byteCount; i++) begin
					if ($fscanf(fd, "%h", value) != 1)
						aborted = 1'b1;
					expBytes[i] = value[7:0];
				end
				expCount = byteCount;
				if (aborted)
					$display("data file ends inside test %0s", testName);
				else
					loadAndRun();
			end
		end
		if (fd != 0)
			$fclose(fd);
		if (!aborted && passCount + failCount == 0) begin
			$display("no tests found in tests_input.txt");
			aborted = 1'b1;
		end
		$display("tests run: %0d passed, %0d failed", passCount, failCount);
		if (aborted || failCount != 0)
			$display("SOME TESTS FAILED");
		else
			$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* tests_input.txt */
# Per test: name, instruction word count, expected serial byte count,
# then the instruction words and the expected serial bytes, all in hex
alu 17 7
24010007 2402FFFD 00221821 AC03FFFC 00222023 AC04FFFC 00222824 AC05FFFC
00223025 AC06FFFC 0041382A AC07FFFC 0022402A AC08FFFC 2429007B AC09FFFC
08000010
04 0A 05 FF 01 00 82
forward 14 3
24010003 00211021 00411821 AC03FFFC 24040005 24050001 00853023 AC06FFFC
24070020 24080002 24090003 00E85025 AC0AFFFC 0800000D
09 04 22
forward_padded 34 3
24010003 00000000 00000000 00000000 00211021 00000000 00000000 00000000
00411821 00000000 00000000 00000000 AC03FFFC 24040005 24050001 00000000
00000000 00000000 00853023 00000000 00000000 00000000 AC06FFFC 24070020
24080002 00000000 00000000 00000000 00E85025 00000000 00000000 00000000
AC0AFFFC 08000021
09 04 22
loaduse 8 2
24010055 AC010010 8C020010 24430001 AC03FFFC 8C040010 AC04FFFC 08000007
56 55
branch 16 5
24010003 10000001 AC01FFFC 14200001 AC01FFFC 10200001 24020011 AC02FFFC
0800000A AC01FFFC 24030022 AC03FFFC AC01FFFC 2421FFFF 1420FFFD 0800000F
11 22 03 02 01
reload 8 2
24010055 AC010010 8C020010 24430001 AC03FFFC 8C040010 AC04FFFC 08000007
56 55
